// File: source/spi_host_cmd_pkg.sv
`default_nettype none

package spi_host_cmd_pkg;

  // lane configuration of a command
  typedef enum logic [1:0] {
    Standard = 2'b00,
    Dual     = 2'b01,
    Quad     = 2'b10,
    RsvdSpd  = 2'b11
  } speed_e;

  // transmit entry, last marks the final byte of a command
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } tx_byte_t;

  // receive entry, same layout but a distinct type
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } rx_byte_t;

  localparam int unsigned TxDepth = 4;
  localparam int unsigned RxDepth = 4;
  localparam int unsigned ClkDivW = 8;

endpackage

`default_nettype wire

// File: source/spi_host_reg_pkg.sv
`default_nettype none

package spi_host_reg_pkg;

  // word offsets on the APB bus
  localparam logic [3:0] CtrlAddr   = 4'h0;
  localparam logic [3:0] StatusAddr = 4'h4;
  localparam logic [3:0] TxDataAddr = 4'h8;
  localparam logic [3:0] RxDataAddr = 4'hC;

  // control register fields
  localparam int unsigned CtrlSpeedLsb = 0;
  localparam int unsigned CtrlDivLsb   = 8;
  localparam int unsigned CtrlSwRstBit = 31;

  // status register fields
  localparam int unsigned StBusyBit    = 0;
  localparam int unsigned StTxFullBit  = 1;
  localparam int unsigned StRxEmptyBit = 2;

endpackage

`default_nettype wire

// File: source/spi_host_sr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_host_sr_if
  import spi_host_cmd_pkg::*;
();
  // sequencer requests
  logic   wr_en;
  logic   rd_en;
  logic   shift_en;
  logic   sample_en;
  logic   cmd_end;
  speed_e speed;

  // shift register answers
  logic   wr_ready;
  logic   rd_ready;

  modport seq (
    output wr_en, rd_en, shift_en, sample_en, cmd_end, speed,
    input  wr_ready, rd_ready
  );

  modport sr (
    input  wr_en, rd_en, shift_en, sample_en, cmd_end, speed,
    output wr_ready, rd_ready
  );

endinterface

`default_nettype wire

// File: source/spi_host_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clr_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o,
  output logic     full_o,
  output logic     empty_o
);
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  // wrap at Depth so non power of two depths work too
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o      = (count_q == CntW'(Depth));
  assign empty_o     = (count_q == '0);
  assign in_ready_o  = ~full_o;
  assign out_valid_o = ~empty_o;
  assign out_data_o  = mem_q[rd_ptr_q];
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/spi_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host_regs
  import spi_host_cmd_pkg::*;
  import spi_host_reg_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [3:0]         paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  output speed_e             speed_o,
  output logic [ClkDivW-1:0] clkdiv_o,
  output logic               sw_rst_o,
  output logic               tx_valid_o,
  output tx_byte_t           tx_data_o,
  input  logic               tx_ready_i,
  input  logic               rx_valid_i,
  input  rx_byte_t           rx_data_i,
  output logic               rx_ready_o,
  input  logic               busy_i
);
  logic               wr_access;
  logic               rd_access;
  logic               ctrl_wr;
  speed_e             wr_speed;
  speed_e             speed_q;
  logic [ClkDivW-1:0] clkdiv_q;
  logic               sw_rst_q;

  assign wr_access = psel_i & penable_i & pwrite_i;
  assign rd_access = psel_i & penable_i & ~pwrite_i;
  assign ctrl_wr   = wr_access & (paddr_i == CtrlAddr);
  assign wr_speed  = speed_e'(pwdata_i[CtrlSpeedLsb +: $bits(speed_e)]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      speed_q  <= Standard;
      clkdiv_q <= '0;
      sw_rst_q <= 1'b0;
    end else begin
      // self clearing, high for a single cycle
      sw_rst_q <= ctrl_wr & pwdata_i[CtrlSwRstBit];
      if (ctrl_wr) begin
        clkdiv_q <= pwdata_i[CtrlDivLsb +: ClkDivW];
        // reserved speed code keeps the previous setting
        if (wr_speed != RsvdSpd) begin
          speed_q <= wr_speed;
        end
      end
    end
  end

  assign speed_o  = speed_q;
  assign clkdiv_o = clkdiv_q;
  assign sw_rst_o = sw_rst_q;

  // bit 8 of TXDATA carries the last-of-command flag
  assign tx_valid_o = wr_access & (paddr_i == TxDataAddr);
  assign tx_data_o  = tx_byte_t'(pwdata_i[$bits(tx_byte_t)-1:0]);
  assign rx_ready_o = rd_access & (paddr_i == RxDataAddr);

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      CtrlAddr: begin
        prdata_o[CtrlSpeedLsb +: $bits(speed_e)] = speed_q;
        prdata_o[CtrlDivLsb +: ClkDivW]          = clkdiv_q;
      end
      StatusAddr: begin
        prdata_o[StBusyBit]    = busy_i;
        prdata_o[StTxFullBit]  = ~tx_ready_i;
        prdata_o[StRxEmptyBit] = ~rx_valid_i;
      end
      RxDataAddr: prdata_o[$bits(rx_byte_t)-1:0] = rx_data_i;
      default: prdata_o = '0;
    endcase
  end

  // zero wait states, errors on overflow and underflow
  assign pready_o  = 1'b1;
  assign pslverr_o = (tx_valid_o & ~tx_ready_i) | (rx_ready_o & ~rx_valid_i);

endmodule

`default_nettype wire

// File: source/spi_host_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host_fsm
  import spi_host_cmd_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               sw_rst_i,
  input  speed_e             speed_i,
  input  logic [ClkDivW-1:0] clkdiv_i,
  input  logic               tx_valid_i,
  input  logic               tx_last_i,
  output logic               tx_pop_o,
  spi_host_sr_if.seq         sr,
  output logic               sck_o,
  output logic               csb_o,
  output logic               busy_o
);
  typedef enum logic [1:0] {
    Idle,
    Load,
    Shift,
    Wait
  } state_e;

  state_e             state_q;
  logic [ClkDivW-1:0] div_q;
  logic [3:0]         bit_cnt_q;
  logic [3:0]         byte_periods;
  logic               sck_q;
  logic               csb_q;
  logic               last_q;
  logic               rd_done_q;
  logic               half_done;
  logic               rd_ok;

  // SCK periods needed for one byte
  always_comb begin
    case (speed_i)
      Dual:    byte_periods = 4'd4;
      Quad:    byte_periods = 4'd2;
      default: byte_periods = 4'd8;
    endcase
  end

  assign half_done = (div_q == '0);
  assign rd_ok     = rd_done_q | (sr.rd_en & sr.rd_ready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      div_q     <= '0;
      bit_cnt_q <= '0;
      sck_q     <= 1'b0;
      csb_q     <= 1'b1;
      last_q    <= 1'b0;
      rd_done_q <= 1'b0;
    end else if (sw_rst_i) begin
      state_q   <= Idle;
      div_q     <= '0;
      bit_cnt_q <= '0;
      sck_q     <= 1'b0;
      csb_q     <= 1'b1;
      last_q    <= 1'b0;
      rd_done_q <= 1'b0;
    end else begin
      unique case (state_q)
        Idle: begin
          // bit counter doubles as the chip select gap, in half periods
          if (bit_cnt_q != '0) begin
            if (half_done) begin
              div_q     <= clkdiv_i;
              bit_cnt_q <= bit_cnt_q - 1'b1;
            end else begin
              div_q <= div_q - 1'b1;
            end
          end else if (tx_valid_i) begin
            state_q <= Load;
          end
        end
        Load: begin
          // stays here while the transmit FIFO is empty mid command
          if (sr.wr_en && sr.wr_ready) begin
            csb_q     <= 1'b0;
            last_q    <= tx_last_i;
            bit_cnt_q <= byte_periods;
            div_q     <= clkdiv_i;
            state_q   <= Shift;
          end
        end
        Shift: begin
          if (half_done) begin
            div_q <= clkdiv_i;
            sck_q <= ~sck_q;
            // falling edge closes one SCK period
            if (sck_q) begin
              bit_cnt_q <= bit_cnt_q - 1'b1;
              if (bit_cnt_q == 4'd1) begin
                state_q <= Wait;
              end
            end
          end else begin
            div_q <= div_q - 1'b1;
          end
        end
        Wait: begin
          if (!half_done) begin
            div_q <= div_q - 1'b1;
          end
          if (sr.rd_en && sr.rd_ready) begin
            rd_done_q <= 1'b1;
          end
          // last byte also waits out half an SCK period before CS rises
          if (rd_ok && (!last_q || half_done)) begin
            rd_done_q <= 1'b0;
            if (last_q) begin
              csb_q     <= 1'b1;
              bit_cnt_q <= 4'd2;
              div_q     <= clkdiv_i;
              state_q   <= Idle;
            end else begin
              state_q <= Load;
            end
          end
        end
      endcase
    end
  end

  assign sr.wr_en     = (state_q == Load);
  assign sr.rd_en     = (state_q == Wait) & ~rd_done_q;
  assign sr.sample_en = (state_q == Shift) & half_done & ~sck_q;
  assign sr.shift_en  = (state_q == Shift) & half_done & sck_q;
  assign sr.cmd_end   = last_q;
  assign sr.speed     = speed_i;

  assign tx_pop_o = sr.wr_en & sr.wr_ready;
  assign sck_o    = sck_q;
  assign csb_o    = csb_q;
  assign busy_o   = (state_q != Idle);

endmodule

`default_nettype wire

// File: source/spi_host_shift_register.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host_shift_register
  import spi_host_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       sw_rst_i,
  spi_host_sr_if.sr  sr,
  input  logic       tx_valid_i,
  input  logic [7:0] tx_data_i,
  output logic [7:0] rx_data_o,
  output logic       rx_last_o,
  output logic       rx_valid_o,
  input  logic       rx_ready_i,
  input  logic [3:0] sd_i,
  output logic [3:0] sd_o
);
  logic [7:0] sr_q;
  logic [7:0] sr_shifted;
  logic [3:0] sd_i_q;
  rx_byte_t   rx_buf_q;
  logic       rx_buf_valid_q;
  logic       wr_accept;
  logic       rd_accept;

  // MSB first, received bits enter at the bottom
  // standard mode receives on lane 1, not lane 0
  always_comb begin
    case (sr.speed)
      Standard: begin
        sr_shifted = {sr_q[6:0], sd_i_q[1]};
        sd_o       = {3'b000, sr_q[7]};
      end
      Dual: begin
        sr_shifted = {sr_q[5:0], sd_i_q[1:0]};
        sd_o       = {2'b00, sr_q[7:6]};
      end
      Quad: begin
        sr_shifted = {sr_q[3:0], sd_i_q};
        sd_o       = sr_q[7:4];
      end
      default: begin
        sr_shifted = sr_q;
        sd_o       = 4'h0;
      end
    endcase
  end

  // load directly from the FIFO head, no transmit buffer
  assign sr.wr_ready = tx_valid_i;
  assign sr.rd_ready = ~rx_buf_valid_q | rx_ready_i;
  assign wr_accept   = sr.wr_en & sr.wr_ready;
  assign rd_accept   = sr.rd_en & sr.rd_ready;

  assign rx_valid_o = rx_buf_valid_q;
  assign rx_data_o  = rx_buf_q.data;
  assign rx_last_o  = rx_buf_q.last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sr_q           <= '0;
      rx_buf_valid_q <= 1'b0;
    end else if (sw_rst_i) begin
      sr_q           <= '0;
      rx_buf_valid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        sr_q <= tx_data_i;
      end else if (sr.shift_en) begin
        sr_q <= sr_shifted;
      end
      if (rd_accept) begin
        rx_buf_valid_q <= 1'b1;
      end else if (rx_ready_i) begin
        rx_buf_valid_q <= 1'b0;
      end
    end
  end

  // lane inputs captured on rising SCK, byte captured at its boundary
  always_ff @(posedge clk_i) begin
    if (sr.sample_en) begin
      sd_i_q <= sd_i;
    end
    if (rd_accept) begin
      rx_buf_q.last <= sr.cmd_end;
      rx_buf_q.data <= sr_q;
    end
  end

endmodule

`default_nettype wire

// File: source/spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host
  import spi_host_cmd_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [3:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        sck_o,
  output logic        csb_o,
  output logic [3:0]  sd_o,
  input  logic [3:0]  sd_i
);
  speed_e             speed;
  logic [ClkDivW-1:0] clkdiv;
  logic               sw_rst;
  logic               busy;
  logic               tx_push_valid;
  logic               tx_push_ready;
  tx_byte_t           tx_push_data;
  logic               tx_head_valid;
  logic               tx_pop;
  tx_byte_t           tx_head;
  logic               rx_push_valid;
  logic               rx_push_ready;
  rx_byte_t           rx_push_data;
  logic               rx_head_valid;
  logic               rx_pop;
  rx_byte_t           rx_head;

  spi_host_sr_if sr_if ();

  spi_host_regs i_regs (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .speed_o    (speed),
    .clkdiv_o   (clkdiv),
    .sw_rst_o   (sw_rst),
    .tx_valid_o (tx_push_valid),
    .tx_data_o  (tx_push_data),
    .tx_ready_i (tx_push_ready),
    .rx_valid_i (rx_head_valid),
    .rx_data_i  (rx_head),
    .rx_ready_o (rx_pop),
    .busy_i     (busy)
  );

  spi_host_fifo #(.payload_t(tx_byte_t), .Depth(TxDepth)) i_tx_fifo (
    .clk_i, .rst_ni,
    .clr_i       (sw_rst),
    .in_valid_i  (tx_push_valid),
    .in_ready_o  (tx_push_ready),
    .in_data_i   (tx_push_data),
    .out_valid_o (tx_head_valid),
    .out_ready_i (tx_pop),
    .out_data_o  (tx_head),
    .full_o      (),
    .empty_o     ()
  );

  spi_host_fsm i_fsm (
    .clk_i, .rst_ni,
    .sw_rst_i   (sw_rst),
    .speed_i    (speed),
    .clkdiv_i   (clkdiv),
    .tx_valid_i (tx_head_valid),
    .tx_last_i  (tx_head.last),
    .tx_pop_o   (tx_pop),
    .sr         (sr_if.seq),
    .sck_o, .csb_o,
    .busy_o     (busy)
  );

  spi_host_shift_register i_shift_register (
    .clk_i, .rst_ni,
    .sw_rst_i   (sw_rst),
    .sr         (sr_if.sr),
    .tx_valid_i (tx_head_valid),
    .tx_data_i  (tx_head.data),
    .rx_data_o  (rx_push_data.data),
    .rx_last_o  (rx_push_data.last),
    .rx_valid_o (rx_push_valid),
    .rx_ready_i (rx_push_ready),
    .sd_i, .sd_o
  );

  spi_host_fifo #(.payload_t(rx_byte_t), .Depth(RxDepth)) i_rx_fifo (
    .clk_i, .rst_ni,
    .clr_i       (sw_rst),
    .in_valid_i  (rx_push_valid),
    .in_ready_o  (rx_push_ready),
    .in_data_i   (rx_push_data),
    .out_valid_o (rx_head_valid),
    .out_ready_i (rx_pop),
    .out_data_o  (rx_head),
    .full_o      (),
    .empty_o     ()
  );

endmodule

`default_nettype wire

// File: testbench/spi_device_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_device_model
  import spi_host_cmd_pkg::*;
(
  input  speed_e     speed_i,
  input  logic       csb_i,
  // lanes driven by the host
  input  logic [3:0] lanes_i,
  // lanes returned to the host
  output logic [3:0] lanes_o
);

  // loopback device, each returned bit is the inverse of the bit it receives
  // standard mode answers on lane 1, the wide modes on the lanes they drive
  always_comb begin
    lanes_o = 4'h0;
    if (!csb_i) begin
      case (speed_i)
        Standard: begin
          lanes_o[1] = ~lanes_i[0];
        end
        Dual: begin
          lanes_o[1:0] = ~lanes_i[1:0];
        end
        Quad: begin
          lanes_o = ~lanes_i;
        end
        default: begin
          lanes_o = 4'h0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_host
  import spi_host_cmd_pkg::*;
  import spi_host_reg_pkg::*;
();
  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned ResetCycles   = 16;
  localparam int unsigned DriveDelay    = 2;
  localparam int unsigned SampleDelay   = 8;
  localparam int unsigned MaxClkDiv     = 3;
  localparam int unsigned ApbCycles     = 12;
  localparam int unsigned MaxByteCycles = 8 * 2 * (MaxClkDiv + 1) + ApbCycles;
  localparam int unsigned NumBytes      = 24;
  localparam int unsigned HoldCycles    = 64;
  localparam int unsigned WatchdogNs    =
    NumBytes * MaxByteCycles * 2 * ClkPeriod + ResetCycles * ClkPeriod;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [3:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic        sck_o;
  logic        csb_o;
  logic [3:0]  sd_o;
  logic [3:0]  sd_i;
  speed_e      cur_speed;

  logic [15:0] lfsr_q = 16'd77;
  logic [8:0]  ref_q [$];

  int unsigned csb_falls = 0;
  int unsigned csb_rises = 0;
  int unsigned sck_rises = 0;
  logic        csb_prev  = 1'b1;
  logic        sck_prev  = 1'b0;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  spi_host i_spi_host (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .sck_o, .csb_o, .sd_o, .sd_i
  );

  spi_device_model i_device (
    .speed_i (cur_speed),
    .csb_i   (csb_o),
    .lanes_i (sd_o),
    .lanes_o (sd_i)
  );

  // edge counters sampled mid cycle where the SPI outputs are stable
  always @(negedge clk_i) begin
    if (csb_prev && !csb_o) begin
      csb_falls <= csb_falls + 1;
    end
    if (!csb_prev && csb_o) begin
      csb_rises <= csb_rises + 1;
    end
    if (!sck_prev && sck_o) begin
      sck_rises <= sck_rises + 1;
    end
    csb_prev <= csb_o;
    sck_prev <= sck_o;
  end

  task automatic stop_on_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("ERR %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    $display("Test failures found");
    $fatal(1, "%s mismatch", name);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else stop_on_error(name, expected, actual);
  endtask

  // SCK stays low whenever the device is deselected
  sck_idle_deselected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csb_o |-> !sck_o) else stop_on_error("sck_o", 0, $sampled(sck_o));

  zero_wait_states: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_o) else stop_on_error("pready_o", 1, $sampled(pready_o));

  pslverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_o |-> (psel_i && penable_i)) else stop_on_error("pslverr_o", 0, $sampled(pslverr_o));

  function automatic logic [15:0] next_lfsr(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  // one LFSR step per bit
  task automatic random_byte(output logic [7:0] value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      value  = {value[6:0], lfsr_q[0]};
      lfsr_q = next_lfsr(lfsr_q);
    end
  endtask

  function automatic logic [31:0] ctrl_word(input speed_e speed, input logic [7:0] div,
                                            input logic sw_rst);
    logic [31:0] word;
    word                        = '0;
    word[CtrlSpeedLsb +: 2]     = speed;
    word[CtrlDivLsb +: ClkDivW] = div;
    word[CtrlSwRstBit]          = sw_rst;
    return word;
  endfunction

  // setup phase, access phase, then release the bus
  task automatic bus_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk_i);
    #(DriveDelay);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = write ? wdata : '0;
    @(posedge clk_i);
    #(DriveDelay);
    penable_i = 1'b1;
    #(SampleDelay);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    #(DriveDelay);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_transfer(1'b1, addr, data, rdata, err);
    check_value("pslverr_o", exp_err, err);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          input logic exp_err);
    logic err;
    bus_transfer(1'b0, addr, '0, data, err);
    check_value("pslverr_o", exp_err, err);
  endtask

  task automatic configure(input speed_e speed, input logic [7:0] div);
    write_reg(CtrlAddr, ctrl_word(speed, div, 1'b0), 1'b0);
    cur_speed = speed;
  endtask

  task automatic push_tx_byte(input logic last);
    logic [31:0] status;
    logic [7:0]  data;
    random_byte(data);
    do begin
      read_reg(StatusAddr, status, 1'b0);
    end while (status[StTxFullBit]);
    write_reg(TxDataAddr, {23'h0, last, data}, 1'b0);
    // device returns the inverted byte with the same flag
    ref_q.push_back({last, ~data});
  endtask

  task automatic read_rx_byte();
    logic [31:0] status;
    logic [31:0] data;
    logic [8:0]  expected;
    do begin
      read_reg(StatusAddr, status, 1'b0);
    end while (status[StRxEmptyBit]);
    read_reg(RxDataAddr, data, 1'b0);
    expected = ref_q.pop_front();
    check_value("rxdata", {23'h0, expected}, data);
  endtask

  task automatic wait_cmd_end(input int unsigned target);
    logic [31:0] status;
    wait (csb_rises >= target);
    read_reg(StatusAddr, status, 1'b0);
    check_value("status.busy", 0, status[StBusyBit]);
    check_value("csb_o", 1, csb_o);
  endtask

  task automatic run_command(input int unsigned n);
    int unsigned base_falls;
    int unsigned target;
    base_falls = csb_falls;
    target     = csb_rises + 1;
    for (int unsigned i = 0; i < n; i++) begin
      push_tx_byte(i == n - 1);
    end
    wait_cmd_end(target);
    // a single select window covers the whole command
    check_value("csb_o falls", base_falls + 1, csb_falls);
    for (int unsigned i = 0; i < n; i++) begin
      read_rx_byte();
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic [7:0]  data;
    int unsigned base_sck;
    int unsigned target;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    cur_speed = Standard;
    rst_ni    = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;

    check_value("csb_o", 1, csb_o);
    check_value("sck_o", 0, sck_o);
    check_value("sd_o", 0, sd_o);
    read_reg(StatusAddr, rdata, 1'b0);
    check_value("status.busy", 0, rdata[StBusyBit]);
    check_value("status.rx_empty", 1, rdata[StRxEmptyBit]);

    configure(Standard, 8'd1);
    run_command(3);
    configure(Dual, 8'd0);
    run_command(3);
    configure(Quad, 8'd3);
    run_command(3);

    // reserved speed code is dropped
    write_reg(CtrlAddr, ctrl_word(RsvdSpd, 8'd3, 1'b0), 1'b0);
    read_reg(CtrlAddr, rdata, 1'b0);
    check_value("ctrl.speed", Quad, rdata[CtrlSpeedLsb +: 2]);

    // back-pressure with the receive side left unread
    configure(Standard, 8'd1);
    base_sck = sck_rises;
    target   = csb_rises + 1;
    for (int i = 0; i < 8; i++) begin
      push_tx_byte(i == 7);
    end
    // four bytes in the FIFO, one in the buffer, the sixth held at its boundary
    wait (sck_rises >= base_sck + 6 * 8);
    repeat (HoldCycles) @(posedge clk_i);
    check_value("sck_o rises", base_sck + 6 * 8, sck_rises);
    check_value("sck_o", 0, sck_o);
    check_value("csb_o", 0, csb_o);
    read_reg(StatusAddr, rdata, 1'b0);
    check_value("status.busy", 1, rdata[StBusyBit]);
    check_value("status.rx_empty", 0, rdata[StRxEmptyBit]);
    for (int i = 0; i < 8; i++) begin
      read_rx_byte();
    end
    wait_cmd_end(target);

    // bus errors, then software reset mid command
    configure(Standard, 8'd3);
    read_reg(RxDataAddr, rdata, 1'b1);
    read_reg(StatusAddr, rdata, 1'b0);
    while (!rdata[StTxFullBit]) begin
      random_byte(data);
      write_reg(TxDataAddr, {24'h0, data}, 1'b0);
      read_reg(StatusAddr, rdata, 1'b0);
    end
    random_byte(data);
    write_reg(TxDataAddr, {24'h0, data}, 1'b1);
    // the first received byte lands in the receive FIFO while the command goes on
    do begin
      read_reg(StatusAddr, rdata, 1'b0);
    end while (rdata[StRxEmptyBit]);
    check_value("status.busy", 1, rdata[StBusyBit]);
    check_value("csb_o", 0, csb_o);
    write_reg(CtrlAddr, ctrl_word(Standard, 8'd3, 1'b1), 1'b0);
    read_reg(StatusAddr, rdata, 1'b0);
    check_value("status.busy", 0, rdata[StBusyBit]);
    check_value("status.tx_full", 0, rdata[StTxFullBit]);
    check_value("status.rx_empty", 1, rdata[StRxEmptyBit]);
    check_value("csb_o", 1, csb_o);
    check_value("sck_o", 0, sck_o);
    read_reg(RxDataAddr, rdata, 1'b1);

    // pipeline is usable again after the reset
    run_command(1);

    $display("All tests passed!");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("timeout, the SPI commands did not complete within %0d ns", WatchdogNs);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: spi_host.f
source/spi_host_cmd_pkg.sv
source/spi_host_reg_pkg.sv
source/spi_host_sr_if.sv
source/spi_host_fifo.sv
source/spi_host_regs.sv
source/spi_host_fsm.sv
source/spi_host_shift_register.sv
source/spi_host.sv
testbench/spi_device_model.sv
testbench/tb_spi_host.sv
